// ==== compile.f ====
+incdir+.
wb_mem_pkg.sv
wb_mem_front.sv
sdp_bwe_bram.sv
wb_mem_ack.sv
wb_mem_top.sv
tb_wb_mem.sv

// ==== Makefile ====
# Verilator build of the Wishbone memory testbench
# Exit status of the test target is the simulation result

TOP := tb_wb_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== tb_wb_mem_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference memory and bus tasks, included inside tb_wb_mem
// Tasks must be entered on a falling edge of clkb
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_WB_MEM_MODEL_SVH
`define TB_WB_MEM_MODEL_SVH

  logic [word_w-1:0] model_mem [mem_depth];   // Expected RAM contents

  // Block RAM powers up as zero
  task automatic model_clear();
    for (int a = 0; a < mem_depth; a++) begin
      model_mem[a] = '0;
    end
  endtask

  // Merge only the selected lanes into the stored word
  task automatic model_write(input logic [addr_w-1:0]     addr,
                             input logic [word_bytes-1:0] lanes,
                             input logic [word_w-1:0]     data);
    for (int i = 0; i < word_bytes; i++) begin
      if (lanes[i]) begin
        model_mem[addr][i*byte_w +: byte_w] = data[i*byte_w +: byte_w];
      end
    end
  endtask

  // One classic cycle, stb held until ack, latency checked against the rule
  task automatic bus_cycle(input  logic                  wr,
                           input  logic [addr_w-1:0]     addr,
                           input  logic [word_bytes-1:0] lanes,
                           input  logic [word_w-1:0]     data,
                           output logic [word_w-1:0]     rdata);
    int n;
    n          = 0;
    cyc        = 1'b1;
    stb        = 1'b1;
    we         = wr;
    adr        = addr;
    sel        = lanes;
    dat_w.word = data;
    do begin
      @(negedge clkb);
      n++;                                      // Cycles since the request went out
    end while (ack !== 1'b1);
    check_eq(n, wr ? wr_latency : rd_latency, "ack latency");
    rdata = dat_r.word;                         // Valid together with ack
    @(negedge clkb);                            // Request held through the ack edge
    check_eq(ack, 1'b0, "ack longer than one cycle");
    cyc   = 1'b0;                               // End of cycle
    stb   = 1'b0;
    we    = 1'b0;
    @(negedge clkb);                            // stb low for at least one edge
    check_eq(ack, 1'b0, "ack after the cycle ended");
  endtask

  task automatic bus_write(input logic [addr_w-1:0]     addr,
                           input logic [word_bytes-1:0] lanes,
                           input logic [word_w-1:0]     data);
    logic [word_w-1:0] unused;
    bus_cycle(1'b1, addr, lanes, data, unused);
    model_write(addr, lanes, data);
  endtask

  // Read ignores sel, whole word compared
  task automatic bus_read(input logic [addr_w-1:0] addr);
    logic [word_w-1:0] rdata;
    bus_cycle(1'b0, addr, {word_bytes{1'b1}}, '0, rdata);
    check_eq(rdata, model_mem[addr], "read data");
  endtask

  // Bus idle, no stray ack allowed
  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(negedge clkb);
      check_eq(ack, 1'b0, "ack while bus idle");
    end
  endtask

`endif

// ==== tb_wb_mem.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random Wishbone master against a reference memory, fixed seed
// Stops at the first mismatch, cycle limit guards a hung bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_wb_mem;
  import wb_mem_pkg::*;

  localparam int clk_period = 4;                   // Time units per clkb cycle
  localparam int rst_cycles = 4;                   // Cycles with rstb high
  localparam int num_trans  = 400;                 // Random transactions
  localparam int wr_latency = 1;                   // Write issue to ack, in cycles
  localparam int max_cycles = num_trans * 6 + 20;  // Worst read with its gap is 6 cycles

  logic                  clkb;
  logic                  rstb;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [addr_w-1:0]     adr;
  logic [word_bytes-1:0] sel;
  mem_word_t             dat_w;
  mem_word_t             dat_r;
  logic                  ack;

  integer seed;                                    // $random state
  int     cycles = 0;                              // Clock edges since start

  wb_mem_top uut (
    .clkb  (clkb),
    .rstb  (rstb),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  always #(clk_period / 2) clkb = ~clkb;

  // Compare and stop on the first difference
  task automatic check_eq(input logic [31:0] got,
                          input logic [31:0] exp,
                          input string       msg);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, msg, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  `include "tb_wb_mem_model.svh"

  always @(posedge clkb) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the bus hung waiting for ack", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped on timeout");
    end
  end

  initial begin
    logic [31:0]       r;
    logic [word_w-1:0] data;
    logic [addr_w-1:0] addr;
    logic [addr_w-1:0] last_wr;
    int                gap;
    seed    = 88188;
    clkb    = 1'b0;
    rstb    = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = '0;
    sel     = '0;
    dat_w   = '0;
    last_wr = '0;
    model_clear();

    // Output register and ack cleared by reset
    repeat (rst_cycles) begin
      @(negedge clkb);
      check_eq(ack, 1'b0, "ack during reset");
      check_eq(dat_r.word, '0, "dat_r during reset");
    end
    rstb = 1'b0;
    @(negedge clkb);
    check_eq(ack, 1'b0, "ack after reset");
    check_eq(dat_r.word, '0, "dat_r after reset");

    for (int t = 0; t < num_trans; t++) begin
      r    = $random(seed);
      data = $random(seed);
      addr = r[16 +: addr_w];
      if (!r[8]) begin
        addr[addr_w-1:4] = '0;                     // Small window, forces lane merges
      end
      case (r[1:0])
        2'd0, 2'd1: begin
          bus_write(addr, r[4 +: word_bytes], data);
          last_wr = addr;
        end
        2'd2: bus_read(addr);                      // Often a never-written word
        default: bus_read(last_wr);                // Readback of latest write
      endcase
      gap = int'(r[11:10]) % 3;                    // 0 to 2 extra idle cycles
      idle_cycles(gap);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== wb_mem_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave, one open transaction, no err/rty/stall
// Address wraps at the RAM depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wb_mem_top (
  input  logic                               clkb,    // Single clock
  input  logic                               rstb,    // Sync reset, active high
  input  logic                               cyc,     // Wishbone cycle
  input  logic                               stb,     // Wishbone strobe
  input  logic                               we,      // Write enable
  input  logic [wb_mem_pkg::addr_w-1:0]      adr,     // Word address
  input  logic [wb_mem_pkg::word_bytes-1:0]  sel,     // Byte select
  input  wb_mem_pkg::mem_word_t              dat_w,   // Write data
  output wb_mem_pkg::mem_word_t              dat_r,   // Read data
  output logic                               ack      // Acknowledge
);
  import wb_mem_pkg::*;

  logic [word_bytes-1:0] wr_en;     // Lane write enables
  logic [addr_w-1:0]     wr_addr;   // RAM write address
  logic [addr_w-1:0]     rd_addr;   // RAM read address
  mem_word_t             wr_data;   // Lane-routed write word
  logic                  rd_en;     // RAM read latch enable
  logic                  wr_done;   // Write issue pulse
  logic                  rd_issue;  // Read issue pulse
  logic                  out_ce;    // Output register enable
  mem_word_t             rd_q;      // Registered RAM word

  // Bus request to RAM access
  wb_mem_front u_front (
    .clkb     (clkb),
    .rstb     (rstb),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .sel      (sel),
    .dat_w    (dat_w),
    .ack      (ack),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .wr_done  (wr_done),
    .rd_issue (rd_issue)
  );

  // Byte-write RAM, registered output
  sdp_bwe_bram u_ram (
    .clkb    (clkb),
    .rstb    (rstb),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .out_ce  (out_ce),
    .rd_q    (rd_q)
  );

  // Latency tracking and bus response
  wb_mem_ack u_ack (
    .clkb     (clkb),
    .rstb     (rstb),
    .cyc      (cyc),
    .wr_done  (wr_done),
    .rd_issue (rd_issue),
    .rd_q     (rd_q),
    .out_ce   (out_ce),
    .ack      (ack),
    .dat_r    (dat_r)
  );

endmodule

// ==== wb_mem_ack.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write ack one cycle after issue, read ack after rd_latency
// A read pending when cyc drops is discarded
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wb_mem_ack (
  input  logic                   clkb,      // Bus clock
  input  logic                   rstb,      // Sync reset, active high
  input  logic                   cyc,       // Wishbone cycle, aborts pending read
  input  logic                   wr_done,   // Write issued this cycle
  input  logic                   rd_issue,  // Read issued this cycle
  input  wb_mem_pkg::mem_word_t  rd_q,      // Registered RAM word
  output logic                   out_ce,    // RAM output register enable
  output logic                   ack,       // Wishbone acknowledge
  output wb_mem_pkg::mem_word_t  dat_r      // Wishbone read data
);
  import wb_mem_pkg::*;

  logic [rd_latency-1:0] rd_pend;   // Read in flight, one bit per stage
  logic                  wr_ack;    // Registered write issue

  always_ff @(posedge clkb) begin
    if (rstb) begin
      rd_pend <= '0;
      wr_ack  <= 1'b0;
    end else begin
      wr_ack <= wr_done;            // Ack in the cycle after the write
      if (!cyc) begin
        rd_pend <= '0;              // Master gave up, drop the read
      end else begin
        rd_pend <= {rd_pend[rd_latency-2:0], rd_issue};
      end
    end
  end

  assign out_ce = rd_pend[0];                       // Latch to output register
  assign ack    = rd_pend[rd_latency-1] | wr_ack;   // Data valid with last stage
  assign dat_r  = rd_q;                             // Held until next read

  // Ack only inside a bus cycle
  a_ack_in_cyc: assert property (
    @(posedge clkb) disable iff (rstb)
    ack |-> cyc
  ) else $error("ack outside of cyc");

  // Ack is a single-cycle pulse
  a_ack_pulse: assert property (
    @(posedge clkb) disable iff (rstb)
    ack |=> !ack
  ) else $error("ack high two cycles in a row");

endmodule

// ==== sdp_bwe_bram.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Contents power up as zero, reset clears only the output register
// Same-cycle read of a written address returns the old word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module sdp_bwe_bram (
  input  logic                               clkb,      // Single clock, both ports
  input  logic                               rstb,      // Output register reset
  input  logic [wb_mem_pkg::word_bytes-1:0]  wr_en,     // Byte-lane write enable
  input  logic [wb_mem_pkg::addr_w-1:0]      wr_addr,   // Write port address
  input  logic [wb_mem_pkg::addr_w-1:0]      rd_addr,   // Read port address
  input  wb_mem_pkg::mem_word_t              wr_data,   // Write port data
  input  logic                               rd_en,     // Read latch enable
  input  logic                               out_ce,    // Output register enable
  output wb_mem_pkg::mem_word_t              rd_q       // Registered read word
);
  import wb_mem_pkg::*;

  mem_word_t mem [mem_depth];   // Storage array
  mem_word_t rd_lat;            // RAM read latch, first read stage

  // Zero contents at power up, matches block RAM default
  initial begin
    for (int a = 0; a < mem_depth; a++) begin
      mem[a] = '0;
    end
  end

  // Write port, each lane independent
  always @(posedge clkb) begin
    for (int i = 0; i < word_bytes; i++) begin
      if (wr_en[i]) begin
        mem[wr_addr].lanes[i] <= wr_data.lanes[i];
      end
    end
  end

  // Read port latch, sees the pre-write word on a collision
  always @(posedge clkb) begin
    if (rd_en) begin
      rd_lat <= mem[rd_addr];
    end
  end

  // Output register, second read stage
  always_ff @(posedge clkb) begin
    if (rstb) begin
      rd_q <= '0;                   // Contents untouched
    end else if (out_ce) begin
      rd_q <= rd_lat;
    end
  end

  // Output register only loads a word latched on the previous edge
  a_ce_after_rd: assert property (
    @(posedge clkb) disable iff (rstb)
    out_ce |-> $past(rd_en)
  ) else $error("Output register enabled without a preceding read");

  // Write and read ports never active in one cycle
  a_port_excl: assert property (
    @(posedge clkb) disable iff (rstb)
    !((|wr_en) && rd_en)
  ) else $error("Write and read port active together");

endmodule

// ==== wb_mem_front.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One RAM access per Wishbone cycle, stb may be held long
// Dropping cyc abandons the open transaction
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module wb_mem_front (
  input  logic                               clkb,      // Bus and RAM clock
  input  logic                               rstb,      // Sync reset, active high
  input  logic                               cyc,       // Wishbone cycle
  input  logic                               stb,       // Wishbone strobe
  input  logic                               we,        // Write when high
  input  logic [wb_mem_pkg::addr_w-1:0]      adr,       // Word address
  input  logic [wb_mem_pkg::word_bytes-1:0]  sel,       // Byte lane select
  input  wb_mem_pkg::mem_word_t              dat_w,     // Write data from master
  input  logic                               ack,       // Transaction end
  output logic [wb_mem_pkg::word_bytes-1:0]  wr_en,     // Per-lane write enable
  output logic [wb_mem_pkg::addr_w-1:0]      wr_addr,   // RAM write address
  output logic [wb_mem_pkg::addr_w-1:0]      rd_addr,   // RAM read address
  output wb_mem_pkg::mem_word_t              wr_data,   // Lane-routed write data
  output logic                               rd_en,     // RAM read latch enable
  output logic                               wr_done,   // Write issued this cycle
  output logic                               rd_issue   // Read issued this cycle
);
  import wb_mem_pkg::*;

  logic busy;     // Access issued, ack not yet seen
  logic strobe;   // Qualified bus request
  logic issue;    // Access goes out at the coming edge
  logic wr_go;    // Issue is a write
  logic rd_go;    // Issue is a read

  assign strobe = cyc & stb;
  assign issue  = strobe & ~busy;   // Only from idle
  assign wr_go  = issue & we;
  assign rd_go  = issue & ~we;

  // Busy from the issue edge until the ack edge
  always_ff @(posedge clkb) begin
    if (rstb) begin
      busy <= 1'b0;
    end else if (ack || !cyc) begin
      busy <= 1'b0;                 // Transaction ended or abandoned
    end else if (issue) begin
      busy <= 1'b1;
    end
  end

  // Write lanes gated by sel, unselected lanes held at zero
  always_comb begin
    for (int i = 0; i < word_bytes; i++) begin
      wr_en[i]         = wr_go & sel[i];
      wr_data.lanes[i] = sel[i] ? dat_w.lanes[i] : '0;
    end
  end

  assign wr_addr  = adr;
  assign rd_addr  = adr;            // Read ignores sel, full word returned
  assign rd_en    = rd_go;
  assign wr_done  = wr_go;          // Write ack timing starts here
  assign rd_issue = rd_go;          // Read latency starts here

  // No second issue until the open transaction ends
  a_one_issue: assert property (
    @(posedge clkb) disable iff (rstb)
    (wr_done || rd_issue) |=> !(wr_done || rd_issue) until_with (ack || !cyc)
  ) else $error("Second access issued within one transaction");

endmodule

// ==== wb_mem_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// All sizes are fixed here, with no per-module overrides
// Read path always uses the RAM output register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package wb_mem_pkg;

  // Data organisation
  localparam int byte_w     = 8;                    // Bits per byte lane
  localparam int word_bytes = 4;                    // Lanes per word, width of sel
  localparam int word_w     = word_bytes * byte_w;  // Wishbone data width

  // Memory organisation
  localparam int mem_depth  = 256;                  // Words in the RAM
  localparam int addr_w     = $clog2(mem_depth);    // Word address bits, no decode above

  // Edges from read issue to data in the output register
  // One edge for the RAM latch, one for the output register
  localparam int rd_latency = 2;

  // One data word, seen whole or lane by lane
  typedef union packed {
    logic [word_w-1:0]                  word;   // Whole word, bus side
    logic [word_bytes-1:0][byte_w-1:0]  lanes;  // Lane 0 is the low byte
  } mem_word_t;

endpackage
